//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu = 2'b00,  // alu result
        wb_imm = 2'b01,  // lui
        wb_pc4 = 2'b10,  // jal return address
        wb_mem = 2'b11   // load data
    } wb_sel_t;

    // branch funct3
    localparam logic [2:0] br_eq  = 3'b000;
    localparam logic [2:0] br_ne  = 3'b001;
    localparam logic [2:0] br_lt  = 3'b100;
    localparam logic [2:0] br_ge  = 3'b101;
    localparam logic [2:0] br_ltu = 3'b110;
    localparam logic [2:0] br_geu = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_sb_t;

    typedef union packed {
        inst_r_t  r;
        inst_sb_t sb;  // store and branch immediates
    } inst_u;

    localparam logic [31:0] bubble_inst = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  redirect,
    input  xlen_t redirect_pc,
    output xlen_t pc
);

    xlen_t pc_next;

    // redirect wins over a load-use hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + xlen_t'(4);  // always predict not-taken
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- source/decoder.sv
`default_nettype none

module decoder import rv_pkg::*; (
    input  inst_u   inst,
    output alu_op_t alu_op,
    output logic    use_imm,
    output logic    reg_write,
    output logic    mem_read,
    output logic    mem_write,
    output logic    branch,
    output logic    jump,
    output wb_sel_t wb_sel,
    output xlen_t   imm
);

    logic [6:0] opcode;
    alu_op_t    funct_op;  // alu op from funct3/funct7
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign opcode = inst.r.opcode;

    assign imm_i = {{52{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
    assign imm_s = {{52{inst.sb.imm_hi[6]}}, inst.sb.imm_hi, inst.sb.imm_lo};
    assign imm_b = {{51{inst.sb.imm_hi[6]}}, inst.sb.imm_hi[6], inst.sb.imm_lo[0],
                    inst.sb.imm_hi[5:0], inst.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {{32{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2, inst.r.rs1,
                    inst.r.funct3, 12'b0};
    assign imm_j = {{43{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rs1, inst.r.funct3,
                    inst.r.rs2[0], inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

    always_comb begin
        case (inst.r.funct3)
            3'b000:  funct_op = (opcode == op_reg && inst.r.funct7[5]) ? alu_sub : alu_add;
            3'b001:  funct_op = alu_sll;
            3'b010:  funct_op = alu_slt;
            3'b011:  funct_op = alu_sltu;
            3'b100:  funct_op = alu_xor;
            3'b101:  funct_op = inst.r.funct7[5] ? alu_sra : alu_srl;  // bit 30 in both forms
            3'b110:  funct_op = alu_or;
            default: funct_op = alu_and;
        endcase
    end

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        wb_sel    = wb_alu;
        imm       = '0;
        case (opcode)
            op_reg: begin
                alu_op    = funct_op;
                reg_write = 1'b1;
            end
            op_imm: begin
                alu_op    = funct_op;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                imm       = imm_i;
            end
            op_lui: begin
                reg_write = 1'b1;
                wb_sel    = wb_imm;
                imm       = imm_u;
            end
            op_load: begin
                use_imm   = 1'b1;  // address is rs1 + imm
                reg_write = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = wb_mem;
                imm       = imm_i;
            end
            op_store: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
            end
            op_branch: begin
                branch = 1'b1;
                imm    = imm_b;
            end
            op_jal: begin
                jump      = 1'b1;
                reg_write = 1'b1;
                wb_sel    = wb_pc4;
                imm       = imm_j;
            end
            default: ;  // unknown opcode acts as a bubble
        endcase
    end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd_addr,
    input  xlen_t     rd_data
);

    xlen_t regs [1:31];  // no storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    function automatic xlen_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == rd_addr) begin
            return rd_data;  // write-through from writeback
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`default_nettype none

module hazard_unit import rv_pkg::*; (
    input  reg_addr_t  ex_rs1,
    input  reg_addr_t  ex_rs2,
    input  reg_addr_t  mem_rd,
    input  reg_addr_t  wb_rd,
    input  logic       mem_reg_write,
    input  logic       wb_reg_write,
    input  logic       ex_mem_read,
    input  reg_addr_t  ex_rd,
    input  reg_addr_t  id_rs1,
    input  reg_addr_t  id_rs2,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       stall
);

    // 2'b10 memory stage, 2'b01 writeback, 2'b00 register file
    function automatic logic [1:0] fwd_sel(input reg_addr_t rs);
        if (rs == '0) begin
            return 2'b00;
        end else if (mem_reg_write && mem_rd == rs) begin
            return 2'b10;  // youngest result first
        end else if (wb_reg_write && wb_rd == rs) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    always_comb begin
        fwd_a = fwd_sel(ex_rs1);
        fwd_b = fwd_sel(ex_rs2);
    end

    // load result not ready until writeback
    assign stall = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`default_nettype none

module execute_unit import rv_pkg::*; (
    input  xlen_t      pc,
    input  xlen_t      rs1_data,
    input  xlen_t      rs2_data,
    input  xlen_t      imm,
    input  alu_op_t    alu_op,
    input  logic       use_imm,
    input  logic       branch,
    input  logic       jump,
    input  logic [2:0] funct3,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  xlen_t      mem_result,
    input  xlen_t      wb_result,
    output xlen_t      result,
    output xlen_t      store_data,
    output logic       redirect,
    output xlen_t      redirect_pc
);

    xlen_t op_a;
    xlen_t rs2_fwd;
    xlen_t op_b;
    logic  take;

    function automatic xlen_t fwd_mux(input logic [1:0] sel, input xlen_t reg_val,
                                      input xlen_t mem_val, input xlen_t wb_val);
        case (sel)
            2'b10:   return mem_val;
            2'b01:   return wb_val;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a    = fwd_mux(fwd_a, rs1_data, mem_result, wb_result);
        rs2_fwd = fwd_mux(fwd_b, rs2_data, mem_result, wb_result);
    end

    assign op_b       = use_imm ? imm : rs2_fwd;
    assign store_data = rs2_fwd;  // stores use forwarded rs2

    always_comb begin
        case (alu_op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_or:   result = op_a | op_b;
            alu_xor:  result = op_a ^ op_b;
            alu_sll:  result = op_a << op_b[5:0];
            alu_srl:  result = op_a >> op_b[5:0];
            alu_sra:  result = $signed(op_a) >>> op_b[5:0];
            alu_slt:  result = {63'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {63'b0, op_a < op_b};
            default:  result = op_a + op_b;
        endcase
    end

    // branch compares registers, never the immediate
    always_comb begin
        case (funct3)
            br_eq:   take = (op_a == rs2_fwd);
            br_ne:   take = (op_a != rs2_fwd);
            br_lt:   take = ($signed(op_a) < $signed(rs2_fwd));
            br_ge:   take = ($signed(op_a) >= $signed(rs2_fwd));
            br_ltu:  take = (op_a < rs2_fwd);
            br_geu:  take = (op_a >= rs2_fwd);
            default: take = 1'b0;
        endcase
    end

    assign redirect    = jump || (branch && take);
    assign redirect_pc = pc + imm;  // same adder for branch and jal

endmodule

`default_nettype wire

//--- source/scpu_top.sv
`default_nettype none

module scpu_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  inst_u inst,
    input  xlen_t data_in,    // same-cycle load data
    output xlen_t pc_out,     // to instruction memory
    output xlen_t addr_out,
    output xlen_t data_out,
    output logic  mem_write
);

    logic       stall;
    logic       redirect;
    xlen_t      redirect_pc;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;

    inst_u      id_inst;
    xlen_t      id_pc;
    alu_op_t    id_alu_op;
    logic       id_use_imm, id_reg_write, id_mem_read, id_mem_write;
    logic       id_branch, id_jump;
    wb_sel_t    id_wb_sel;
    xlen_t      id_imm, id_rs1_data, id_rs2_data;

    xlen_t      ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_t    ex_alu_op;
    logic       ex_use_imm;
    wb_sel_t    ex_wb_sel;
    logic [2:0] ex_funct3;
    reg_addr_t  ex_rs1, ex_rs2, ex_rd;
    logic       ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jump;
    xlen_t      ex_alu_result, ex_store_data, ex_result;

    xlen_t      mem_result, mem_store_data;
    wb_sel_t    mem_wb_sel;
    reg_addr_t  mem_rd;
    logic       mem_reg_write, mem_we;

    xlen_t      wb_result, wb_load_data, wb_value;
    wb_sel_t    wb_wb_sel;
    reg_addr_t  wb_rd;
    logic       wb_reg_write;

    fetch_unit fetch_unit_inst (
        .clk(clk), .arst_n(arst_n), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .pc(pc_out)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_inst <= bubble_inst;
        end else if (redirect) begin
            id_inst <= bubble_inst;  // squash wrong-path fetch
        end else if (!stall) begin
            id_inst <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc_out;
        end
    end

    decoder decoder_inst (
        .inst(id_inst), .alu_op(id_alu_op), .use_imm(id_use_imm), .reg_write(id_reg_write),
        .mem_read(id_mem_read), .mem_write(id_mem_write), .branch(id_branch),
        .jump(id_jump), .wb_sel(id_wb_sel), .imm(id_imm)
    );

    reg_file reg_file_inst (
        .clk(clk), .arst_n(arst_n), .rs1_addr(id_inst.r.rs1), .rs2_addr(id_inst.r.rs2),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data), .we(wb_reg_write),
        .rd_addr(wb_rd), .rd_data(wb_value)
    );

    hazard_unit hazard_unit_inst (
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .mem_reg_write(mem_reg_write), .wb_reg_write(wb_reg_write),
        .ex_mem_read(ex_mem_read), .ex_rd(ex_rd), .id_rs1(id_inst.r.rs1),
        .id_rs2(id_inst.r.rs2), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    // bubble into execute on stall or redirect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_rd        <= '0;
        end else begin
            ex_reg_write <= id_reg_write && id_inst.r.rd != '0 && !redirect && !stall;
            ex_mem_read  <= id_mem_read && !redirect && !stall;
            ex_mem_write <= id_mem_write && !redirect && !stall;
            ex_branch    <= id_branch && !redirect && !stall;
            ex_jump      <= id_jump && !redirect && !stall;
            ex_rd        <= id_inst.r.rd;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= id_pc;
        ex_rs1_data <= id_rs1_data;
        ex_rs2_data <= id_rs2_data;
        ex_imm      <= id_imm;
        ex_alu_op   <= id_alu_op;
        ex_use_imm  <= id_use_imm;
        ex_wb_sel   <= id_wb_sel;
        ex_funct3   <= id_inst.r.funct3;
        ex_rs1      <= id_inst.r.rs1;
        ex_rs2      <= id_inst.r.rs2;
    end

    execute_unit execute_unit_inst (
        .pc(ex_pc), .rs1_data(ex_rs1_data), .rs2_data(ex_rs2_data), .imm(ex_imm),
        .alu_op(ex_alu_op), .use_imm(ex_use_imm), .branch(ex_branch), .jump(ex_jump),
        .funct3(ex_funct3), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(mem_result),
        .wb_result(wb_value), .result(ex_alu_result), .store_data(ex_store_data),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    // loads carry their address to the memory stage
    always_comb begin
        case (ex_wb_sel)
            wb_imm:  ex_result = ex_imm;
            wb_pc4:  ex_result = ex_pc + xlen_t'(4);
            default: ex_result = ex_alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_reg_write <= 1'b0;
            mem_we        <= 1'b0;
            mem_rd        <= '0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_we        <= ex_mem_write;
            mem_rd        <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= ex_result;
        mem_store_data <= ex_store_data;
        mem_wb_sel     <= ex_wb_sel;
    end

    assign addr_out  = mem_result;
    assign data_out  = mem_store_data;
    assign mem_write = mem_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
        end else begin
            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        wb_result    <= mem_result;
        wb_load_data <= data_in;
        wb_wb_sel    <= mem_wb_sel;
    end

    assign wb_value = (wb_wb_sel == wb_mem) ? wb_load_data : wb_result;

endmodule

`default_nettype wire

//--- dv/scpu_asserts.sv
`default_nettype none

module scpu_asserts import rv_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input logic      mem_write,
    input logic      stall,
    input logic      redirect,
    input xlen_t     redirect_pc,
    input xlen_t     pc_out,
    input logic      wb_reg_write,
    input reg_addr_t wb_rd
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // failed assertion count

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !mem_write ##1 !mem_write)
        else begin
            $error("memory write strobe during reset or in the cycle after");
            fail_count++;
        end

    redirect_taken: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> pc_out == $past(redirect_pc))
        else begin
            $error("fetch did not restart at the redirect target");
            fail_count++;
        end

    stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !redirect |=> pc_out == $past(pc_out))
        else begin
            $error("fetch moved on during a load-use stall");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_reg_write && wb_rd == '0))
        else begin
            $error("register write to x0");
            fail_count++;
        end

endmodule

bind scpu_top scpu_asserts scpu_asserts_inst (
    .clk(clk), .arst_n(arst_n), .mem_write(mem_write), .stall(stall), .redirect(redirect),
    .redirect_pc(redirect_pc), .pc_out(pc_out), .wb_reg_write(wb_reg_write), .wb_rd(wb_rd)
);

`default_nettype wire

//--- dv/scpu_tb.sv
`default_nettype none

module scpu_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_progs   = 8;
    localparam int prog_len  = 60;
    localparam int n_dump    = 31;  // one store per register x1..x31
    localparam int dump_base = 256;
    localparam int timeout_cycles = n_progs * (prog_len + n_dump) * 3 + 100;
    localparam xlen_t end_pc = xlen_t'(4 * (prog_len + n_dump));
    localparam logic [2:0] branch_conds [6] = '{br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu};

    logic  clk;
    logic  arst_n;
    inst_u inst;
    xlen_t data_in;
    xlen_t pc_out;
    xlen_t addr_out;
    xlen_t data_out;
    logic  mem_write;

    logic [31:0] imem [0:255];
    xlen_t       dmem [0:31];
    xlen_t       m_regs [0:31];
    xlen_t       m_mem [0:31];
    xlen_t       exp_addr [$];
    xlen_t       exp_data [$];

    int seed = 93142;
    int errors = 0;
    int cycle_count = 0;

    scpu_top scpu_top_inst (
        .clk(clk), .arst_n(arst_n), .inst(inst), .data_in(data_in), .pc_out(pc_out),
        .addr_out(addr_out), .data_out(data_out), .mem_write(mem_write)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // combinational instruction and load ports
    assign inst    = imem[pc_out[9:2]];
    assign data_in = dmem[addr_out[7:3]];

    always @(posedge clk) begin
        if (mem_write) begin
            if (addr_out < dump_base) begin
                dmem[addr_out[7:3]] <= data_out;
            end
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic reg_addr_t pick_reg();
        // mostly x0..x7 so results feed each other
        return (rand_below(4) == 0) ? reg_addr_t'(rand_below(32)) : reg_addr_t'(rand_below(8));
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input logic [2:0] f3,
                                           input reg_addr_t rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                           input logic [2:0] f3, input reg_addr_t rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                           input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};  // sd
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                           input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic build_program();
        int kind;
        int span;
        logic [2:0] f3;
        logic [11:0] imm;
        for (int a = 0; a < 256; a++) begin
            imem[a] = {12'(a), 20'h00013};  // addi x0, x0, a
        end
        for (int a = 0; a < 32; a++) begin
            dmem[a] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < prog_len; i++) begin
            kind = rand_below(8);
            span = (prog_len - i < 4) ? prog_len - i : 4;  // short forward jumps
            f3 = 3'(rand_below(8));
            case (kind)
                0, 1: begin
                    imem[i] = r_type((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) != 0 ?
                                     7'h20 : 7'h00, pick_reg(), pick_reg(), f3, pick_reg(),
                                     op_reg);
                end
                2: begin
                    imm = 12'($random(seed));
                    if (f3 == 3'b001) begin
                        imm[11:6] = '0;
                    end else if (f3 == 3'b101) begin
                        imm[11:6] = rand_below(2) != 0 ? 6'h10 : 6'h00;  // srai or srli
                    end
                    imem[i] = i_type(imm, pick_reg(), f3, pick_reg(), op_imm);
                end
                3: imem[i] = u_type(20'($random(seed)), pick_reg());
                4: imem[i] = i_type(12'(8 * rand_below(32)), '0, 3'b011, pick_reg(), op_load);
                5: imem[i] = s_type(12'(8 * rand_below(32)), pick_reg(), '0);
                6: begin
                    imem[i] = b_type(13'(4 * (1 + rand_below(span))), pick_reg(), pick_reg(),
                                     branch_conds[rand_below(6)]);
                end
                default: imem[i] = j_type(21'(4 * (1 + rand_below(span))), pick_reg());
            endcase
        end
        for (int r = 1; r <= n_dump; r++) begin
            imem[prog_len + r - 1] = s_type(12'(dump_base + 8 * (r - 1)), reg_addr_t'(r), '0);
        end
        imem[prog_len + n_dump] = j_type('0, '0);  // park here
    endtask

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return xlen_t'($signed(a) < $signed(b));
            3'b011:  return xlen_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_lt:   return $signed(a) < $signed(b);
            br_ge:   return $signed(a) >= $signed(b);
            br_ltu:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ISA-level run of one instruction per step
    task automatic run_model();
        logic [31:0] w;
        xlen_t pc;
        xlen_t next_pc;
        xlen_t a;
        xlen_t b;
        xlen_t addr;
        xlen_t res;
        logic wr;
        exp_addr.delete();
        exp_data.delete();
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
            m_mem[r] = dmem[r];
        end
        pc = '0;
        while (pc != end_pc) begin
            w = imem[pc[9:2]];
            a = m_regs[w[19:15]];
            b = m_regs[w[24:20]];
            next_pc = pc + 4;
            res = '0;
            wr = 1'b0;
            case (w[6:0])
                op_reg: begin
                    res = alu_ref(w[14:12], w[30], a, b);
                    wr = 1'b1;
                end
                op_imm: begin
                    res = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a,
                                  {{52{w[31]}}, w[31:20]});
                    wr = 1'b1;
                end
                op_lui: begin
                    res = {{32{w[31]}}, w[31:12], 12'b0};
                    wr = 1'b1;
                end
                op_load: begin
                    addr = a + {{52{w[31]}}, w[31:20]};
                    res = m_mem[addr[7:3]];
                    wr = 1'b1;
                end
                op_store: begin
                    addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    if (addr < dump_base) begin
                        m_mem[addr[7:3]] = b;
                    end
                end
                op_branch: begin
                    if (branch_taken(w[14:12], a, b)) begin
                        next_pc = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    res = pc + 4;
                    wr = 1'b1;
                    next_pc = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                m_regs[w[11:7]] = res;
            end
            pc = next_pc;
        end
    endtask

    task automatic check_addr(input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            $display("Error at %0t: addr_out = %h, expected %h", $time, actual, expected);
            errors++;
        end
    endtask

    task automatic check_data(input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            $display("Error at %0t: data_out = %h, expected %h", $time, actual, expected);
            errors++;
        end
    endtask

    // stores checked in program order
    always @(negedge clk) begin
        if (arst_n && mem_write) begin
            if (exp_addr.size() == 0) begin
                $display("Error at %0t: unexpected store of %h to address %h",
                         $time, data_out, addr_out);
                errors++;
            end else begin
                check_addr(addr_out, exp_addr.pop_front());
                check_data(data_out, exp_data.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d expected stores still missing",
                     cycle_count, exp_addr.size());
            $display("errors: %0d, assertion failures: %0d", errors + 1,
                     scpu_top_inst.scpu_asserts_inst.fail_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        arst_n = 1'b0;
        for (int p = 0; p < n_progs; p++) begin
            @(posedge clk);
            arst_n <= 1'b0;
            build_program();
            run_model();
            repeat (10) @(posedge clk);
            arst_n <= 1'b1;
            while (exp_addr.size() != 0) begin
                @(posedge clk);
            end
        end
        $display("errors: %0d, assertion failures: %0d", errors,
                 scpu_top_inst.scpu_asserts_inst.fail_count);
        if (errors == 0 && scpu_top_inst.scpu_asserts_inst.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/rv_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/hazard_unit.sv
source/execute_unit.sv
source/scpu_top.sv
dv/scpu_asserts.sv
dv/scpu_tb.sv

//--- Bender.yml
package:
  name: scpu

sources:
  - files:
      - source/rv_pkg.sv
      - source/fetch_unit.sv
      - source/decoder.sv
      - source/reg_file.sv
      - source/hazard_unit.sv
      - source/execute_unit.sv
      - source/scpu_top.sv
  - target: test
    files:
      - dv/scpu_asserts.sv
      - dv/scpu_tb.sv
